// File: hw/bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// RAM depth in words, as a power of two
`define RAM_WORDS_LOG2 8

// Edges from RAM request rising to its ready, at least 1
`define RAM_WAIT_CYCLES 3

// Byte base of the register bank, eight words
`define REG_BASE 32'h0001_0000

// Read pattern for addresses that hit no target
`define UNMAPPED_RDATA 32'hDEAD_BEEF

`endif

// File: hw/bus_pkg.sv
`include "bus_defs.svh"

package bus_pkg;

	// Byte address as seen by both masters and the shared bus
	typedef logic [31:0] bus_addr_t;

	// One data word, read or write
	typedef logic [31:0] bus_data_t;

	// Word index into the RAM array
	typedef logic [`RAM_WORDS_LOG2-1:0] ram_index_t;

	// Word index into the register bank
	// 0..3 scratch, 4..7 semaphores
	typedef logic [2:0] reg_index_t;

endpackage

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

	// Arbiter FSM, one grant state per master
	typedef enum logic [1:0] {
		idle,
		grant_b,
		grant_c
	} arbiter_state_t;

	// RAM access FSM
	typedef enum logic {
		ram_idle,
		ram_wait
	} ram_state_t;

endpackage

// File: hw/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
	input  logic                i_clock,
	input  logic                i_arst_n,

	// Port B
	input  logic                i_pb_rw,        // 1 = write
	input  logic                i_pb_request,
	input  bus_pkg::bus_addr_t  i_pb_address,
	input  bus_pkg::bus_data_t  i_pb_wdata,
	output logic                o_pb_ready,
	output bus_pkg::bus_data_t  o_pb_rdata,

	// Port C
	input  logic                i_pc_rw,
	input  logic                i_pc_request,
	input  bus_pkg::bus_addr_t  i_pc_address,
	input  bus_pkg::bus_data_t  i_pc_wdata,
	output logic                o_pc_ready,
	output bus_pkg::bus_data_t  o_pc_rdata,

	// Shared bus
	output logic                o_bus_rw,
	output logic                o_bus_request,
	output bus_pkg::bus_addr_t  o_bus_address,
	output bus_pkg::bus_data_t  o_bus_wdata,
	input  logic                i_bus_ready,
	input  bus_pkg::bus_data_t  i_bus_rdata
);

	ctrl_pkg::arbiter_state_t state;
	ctrl_pkg::arbiter_state_t next_state;

	// Ready only reaches the port that owns the bus
	assign o_pb_ready = (state == ctrl_pkg::grant_b) && i_pb_request && i_bus_ready;
	assign o_pc_ready = (state == ctrl_pkg::grant_c) && i_pc_request && i_bus_ready;

	// Both ports see read data, only one sees ready
	assign o_pb_rdata = i_bus_rdata;
	assign o_pc_rdata = i_bus_rdata;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ctrl_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state    = state;
		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = '0;
		o_bus_wdata   = '0;

		case (state)
			// Fixed priority, B wins a tie
			// Fields go out early with request still low
			ctrl_pkg::idle: begin
				if (i_pb_request) begin
					o_bus_rw      = i_pb_rw;
					o_bus_address = i_pb_address;
					o_bus_wdata   = i_pb_wdata;
					next_state    = ctrl_pkg::grant_b;
				end else if (i_pc_request) begin
					o_bus_rw      = i_pc_rw;
					o_bus_address = i_pc_address;
					o_bus_wdata   = i_pc_wdata;
					next_state    = ctrl_pkg::grant_c;
				end
			end

			ctrl_pkg::grant_b: begin
				o_bus_request = i_pb_request;
				o_bus_rw      = i_pb_rw;
				o_bus_address = i_pb_address;
				o_bus_wdata   = i_pb_wdata;
				if (i_bus_ready) begin
					next_state = ctrl_pkg::idle;   // One idle cycle before next grant
				end
			end

			ctrl_pkg::grant_c: begin
				o_bus_request = i_pc_request;
				o_bus_rw      = i_pc_rw;
				o_bus_address = i_pc_address;
				o_bus_wdata   = i_pc_wdata;
				if (i_bus_ready) begin
					next_state = ctrl_pkg::idle;
				end
			end

			default: begin
				next_state = ctrl_pkg::idle;
			end
		endcase
	end

endmodule

// File: hw/bus_decoder.sv
`timescale 1ns/100ps
`include "bus_defs.svh"

module bus_decoder (
	// Shared bus from the arbiter
	input  logic                  i_bus_rw,
	input  logic                  i_bus_request,
	input  bus_pkg::bus_addr_t    i_bus_address,
	input  bus_pkg::bus_data_t    i_bus_wdata,
	output logic                  o_bus_ready,
	output bus_pkg::bus_data_t    o_bus_rdata,

	// RAM target
	output logic                  o_ram_request,
	output logic                  o_ram_rw,
	output bus_pkg::ram_index_t   o_ram_index,
	output bus_pkg::bus_data_t    o_ram_wdata,
	input  logic                  i_ram_ready,
	input  bus_pkg::bus_data_t    i_ram_rdata,

	// Register bank target
	output logic                  o_reg_request,
	output logic                  o_reg_rw,
	output bus_pkg::reg_index_t   o_reg_index,
	output bus_pkg::bus_data_t    o_reg_wdata,
	input  logic                  i_reg_ready,
	input  bus_pkg::bus_data_t    i_reg_rdata
);

	// Address bits above each window
	localparam int RAM_TOP = `RAM_WORDS_LOG2 + 2;
	localparam int REG_TOP = 5;
	localparam bus_pkg::bus_addr_t REG_BASE = `REG_BASE;

	logic ram_hit;
	logic reg_hit;

	// Byte offset bits [1:0] are ignored, targets are word addressed
	assign ram_hit = (i_bus_address[31:RAM_TOP] == '0);
	assign reg_hit = (i_bus_address[31:REG_TOP] == REG_BASE[31:REG_TOP]);

	assign o_ram_request = i_bus_request && ram_hit;
	assign o_ram_rw      = i_bus_rw;
	assign o_ram_index   = i_bus_address[RAM_TOP-1:2];
	assign o_ram_wdata   = i_bus_wdata;

	assign o_reg_request = i_bus_request && reg_hit;
	assign o_reg_rw      = i_bus_rw;
	assign o_reg_index   = i_bus_address[REG_TOP-1:2];
	assign o_reg_wdata   = i_bus_wdata;

	always_comb begin
		if (ram_hit) begin
			o_bus_ready = i_ram_ready;
			o_bus_rdata = i_ram_rdata;
		end else if (reg_hit) begin
			o_bus_ready = i_reg_ready;
			o_bus_rdata = i_reg_rdata;
		end else begin
			o_bus_ready = i_bus_request;   // Unmapped, answer at once and drop writes
			o_bus_rdata = `UNMAPPED_RDATA;
		end
	end

endmodule

// File: hw/wait_state_ram.sv
`timescale 1ns/100ps
`include "bus_defs.svh"

module wait_state_ram (
	input  logic                  i_clock,
	input  logic                  i_arst_n,
	input  logic                  i_request,
	input  logic                  i_rw,        // 1 = write
	input  bus_pkg::ram_index_t   i_index,
	input  bus_pkg::bus_data_t    i_wdata,
	output logic                  o_ready,
	output bus_pkg::bus_data_t    o_rdata
);

	localparam int WAIT_CYCLES = `RAM_WAIT_CYCLES;
	localparam int COUNT_W     = $clog2(WAIT_CYCLES + 1);
	localparam int DEPTH       = 1 << `RAM_WORDS_LOG2;
	localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(WAIT_CYCLES);

	bus_pkg::bus_data_t   mem [DEPTH];
	ctrl_pkg::ram_state_t state;
	logic [COUNT_W-1:0]   count;       // Edges seen since request rose
	logic                 last_cycle;

	assign last_cycle = (state == ctrl_pkg::ram_wait) && (count == LAST_COUNT);
	assign o_ready    = last_cycle && i_request;

	// Word shows up only in the ready cycle of a read
	assign o_rdata = (o_ready && !i_rw) ? mem[i_index] : '0;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ctrl_pkg::ram_idle;
			count <= '0;
		end else begin
			case (state)
				ctrl_pkg::ram_idle: begin
					if (i_request) begin
						state <= ctrl_pkg::ram_wait;
						count <= COUNT_W'(1);
					end
				end

				ctrl_pkg::ram_wait: begin
					// Done, or the master walked away
					if (last_cycle || !i_request) begin
						state <= ctrl_pkg::ram_idle;
						count <= '0;
					end else begin
						count <= count + COUNT_W'(1);
					end
				end

				default: begin
					state <= ctrl_pkg::ram_idle;
					count <= '0;
				end
			endcase
		end
	end

	// Write lands on the edge that ends the ready cycle
	always_ff @(posedge i_clock) begin
		if (o_ready && i_rw) begin
			mem[i_index] <= i_wdata;
		end
	end

endmodule

// File: hw/semaphore_regs.sv
`timescale 1ns/100ps

module semaphore_regs (
	input  logic                  i_clock,
	input  logic                  i_arst_n,
	input  logic                  i_request,
	input  logic                  i_rw,        // 1 = write
	input  bus_pkg::reg_index_t   i_index,
	input  bus_pkg::bus_data_t    i_wdata,
	output logic                  o_ready,
	output bus_pkg::bus_data_t    o_rdata
);

	bus_pkg::bus_data_t scratch [4];
	logic [3:0]         sem;        // One bit per semaphore word
	logic               sem_sel;
	logic [1:0]         slot;

	assign sem_sel = i_index[2];    // Upper half of the bank
	assign slot    = i_index[1:0];

	// No wait states here
	assign o_ready = i_request;

	always_comb begin
		if (sem_sel) begin
			o_rdata = bus_pkg::bus_data_t'(sem[slot]);   // Value before the set
		end else begin
			o_rdata = scratch[slot];
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sem <= '0;
			for (int i = 0; i < 4; i++) begin
				scratch[i] <= '0;
			end
		end else if (i_request) begin
			if (sem_sel) begin
				// Test-and-set on read, any write releases
				sem[slot] <= !i_rw;
			end else if (i_rw) begin
				scratch[slot] <= i_wdata;
			end
		end
	end

endmodule

// File: hw/dual_master_bus.sv
`timescale 1ns/100ps

module dual_master_bus (
	input  logic                i_clock,
	input  logic                i_arst_n,

	// Port B
	input  logic                i_pb_rw,
	input  logic                i_pb_request,
	input  bus_pkg::bus_addr_t  i_pb_address,
	input  bus_pkg::bus_data_t  i_pb_wdata,
	output logic                o_pb_ready,
	output bus_pkg::bus_data_t  o_pb_rdata,

	// Port C
	input  logic                i_pc_rw,
	input  logic                i_pc_request,
	input  bus_pkg::bus_addr_t  i_pc_address,
	input  bus_pkg::bus_data_t  i_pc_wdata,
	output logic                o_pc_ready,
	output bus_pkg::bus_data_t  o_pc_rdata
);

	// Shared bus, arbiter to decoder
	logic                 bus_rw;
	logic                 bus_request;
	bus_pkg::bus_addr_t   bus_address;
	bus_pkg::bus_data_t   bus_wdata;
	logic                 bus_ready;
	bus_pkg::bus_data_t   bus_rdata;

	// Decoder to RAM
	logic                 ram_request;
	logic                 ram_rw;
	bus_pkg::ram_index_t  ram_index;
	bus_pkg::bus_data_t   ram_wdata;
	logic                 ram_ready;
	bus_pkg::bus_data_t   ram_rdata;

	// Decoder to register bank
	logic                 reg_request;
	logic                 reg_rw;
	bus_pkg::reg_index_t  reg_index;
	bus_pkg::bus_data_t   reg_wdata;
	logic                 reg_ready;
	bus_pkg::bus_data_t   reg_rdata;

	bus_arbiter arbiter0 (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_pb_rw       (i_pb_rw),
		.i_pb_request  (i_pb_request),
		.i_pb_address  (i_pb_address),
		.i_pb_wdata    (i_pb_wdata),
		.o_pb_ready    (o_pb_ready),
		.o_pb_rdata    (o_pb_rdata),
		.i_pc_rw       (i_pc_rw),
		.i_pc_request  (i_pc_request),
		.i_pc_address  (i_pc_address),
		.i_pc_wdata    (i_pc_wdata),
		.o_pc_ready    (o_pc_ready),
		.o_pc_rdata    (o_pc_rdata),
		.o_bus_rw      (bus_rw),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	bus_decoder decoder0 (
		.i_bus_rw      (bus_rw),
		.i_bus_request (bus_request),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata),
		.o_ram_request (ram_request),
		.o_ram_rw      (ram_rw),
		.o_ram_index   (ram_index),
		.o_ram_wdata   (ram_wdata),
		.i_ram_ready   (ram_ready),
		.i_ram_rdata   (ram_rdata),
		.o_reg_request (reg_request),
		.o_reg_rw      (reg_rw),
		.o_reg_index   (reg_index),
		.o_reg_wdata   (reg_wdata),
		.i_reg_ready   (reg_ready),
		.i_reg_rdata   (reg_rdata)
	);

	wait_state_ram ram0 (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_request (ram_request),
		.i_rw      (ram_rw),
		.i_index   (ram_index),
		.i_wdata   (ram_wdata),
		.o_ready   (ram_ready),
		.o_rdata   (ram_rdata)
	);

	semaphore_regs regs0 (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_request (reg_request),
		.i_rw      (reg_rw),
		.i_index   (reg_index),
		.i_wdata   (reg_wdata),
		.o_ready   (reg_ready),
		.o_rdata   (reg_rdata)
	);

endmodule

// File: testbench/tb_dual_master_bus.sv
`timescale 1ns/100ps
`include "bus_defs.svh"

module tb_dual_master_bus;

	localparam int CLK_PERIOD   = 20;
	localparam int RAM_SPAN     = 32;      // RAM words used by the tests
	localparam int MIX_PER_PORT = 150;
	localparam int NUM_TRANS    = 2 * RAM_SPAN + 10 + 2 + 4 + 2 * MIX_PER_PORT;
	localparam int WATCHDOG_CYCLES = 200 * NUM_TRANS + 1000;
	localparam bus_pkg::bus_addr_t RAM_BYTES = 32'(4 << `RAM_WORDS_LOG2);
	localparam bus_pkg::bus_addr_t SEM5_ADDR = `REG_BASE + 32'd20;

	// One completed transfer in completion order
	typedef struct packed {
		logic               port;      // Set for port C
		logic               rw;
		bus_pkg::bus_addr_t addr;
		bus_pkg::bus_data_t wdata;
		bus_pkg::bus_data_t rdata;
	} done_t;

	logic clock;
	logic arst_n;
	logic pb_rw, pb_request, pb_ready;
	logic pc_rw, pc_request, pc_ready;
	bus_pkg::bus_addr_t pb_address, pc_address;
	bus_pkg::bus_data_t pb_wdata, pc_wdata, pb_rdata, pc_rdata;

	done_t done_q[$];
	logic  done_order[$];
	int    issued;
	int    checked;
	integer seed;

	// Reference state
	bus_pkg::bus_data_t ram_model [1 << `RAM_WORDS_LOG2];
	bus_pkg::bus_data_t scratch_model [4];
	logic [3:0]         sem_model;

	// Random mix with B on the lower half and C on the upper
	bus_pkg::bus_addr_t mix_addr  [2 * MIX_PER_PORT];
	bus_pkg::bus_data_t mix_wdata [2 * MIX_PER_PORT];
	logic               mix_rw    [2 * MIX_PER_PORT];
	bus_pkg::bus_data_t rdata_b, rdata_c;

	dual_master_bus dut0 (
		.i_clock      (clock),
		.i_arst_n     (arst_n),
		.i_pb_rw      (pb_rw),
		.i_pb_request (pb_request),
		.i_pb_address (pb_address),
		.i_pb_wdata   (pb_wdata),
		.o_pb_ready   (pb_ready),
		.o_pb_rdata   (pb_rdata),
		.i_pc_rw      (pc_rw),
		.i_pc_request (pc_request),
		.i_pc_address (pc_address),
		.i_pc_wdata   (pc_wdata),
		.o_pc_ready   (pc_ready),
		.o_pc_rdata   (pc_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_data(input string name, input bus_pkg::bus_data_t got,
			input bus_pkg::bus_data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_order(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got port %h, expected port %h",
				name, got, exp));
		end
	endtask

	// Odd stride spreads the test words over every RAM index bit
	function automatic bus_pkg::bus_addr_t ram_slot_addr(input int slot);
		return 32'(((slot * 37) % (1 << `RAM_WORDS_LOG2)) * 4);
	endfunction

	// Returns the expected read value and applies the transfer to the model
	function automatic bus_pkg::bus_data_t ref_access(input bus_pkg::bus_addr_t addr,
			input logic rw, input bus_pkg::bus_data_t wdata);
		bus_pkg::bus_data_t rdata;
		int word;
		rdata = '0;
		if (addr < RAM_BYTES) begin
			word  = int'(addr >> 2);
			rdata = ram_model[word];
			if (rw) ram_model[word] = wdata;
		end else if (addr >= `REG_BASE && addr < `REG_BASE + 32'd32) begin
			word = int'((addr - `REG_BASE) >> 2);
			if (word < 4) begin
				rdata = scratch_model[word];
				if (rw) scratch_model[word] = wdata;
			end else begin
				rdata = {31'd0, sem_model[word - 4]};
				sem_model[word - 4] = !rw;   // Read sets and write clears
			end
		end else begin
			rdata = `UNMAPPED_RDATA;
		end
		return rdata;
	endfunction

	task automatic b_transfer(input logic rw, input bus_pkg::bus_addr_t addr,
			input bus_pkg::bus_data_t wdata, output bus_pkg::bus_data_t rdata);
		@(negedge clock);
		pb_rw      = rw;
		pb_address = addr;
		pb_wdata   = wdata;
		pb_request = 1'b1;
		issued++;
		do @(negedge clock); while (!pb_ready);   // Ready holds until the next rising edge
		rdata = pb_rdata;
		done_q.push_back({1'b0, rw, addr, wdata, rdata});
		done_order.push_back(1'b0);
		@(negedge clock);
		pb_request = 1'b0;
	endtask

	task automatic c_transfer(input logic rw, input bus_pkg::bus_addr_t addr,
			input bus_pkg::bus_data_t wdata, output bus_pkg::bus_data_t rdata);
		@(negedge clock);
		pc_rw      = rw;
		pc_address = addr;
		pc_wdata   = wdata;
		pc_request = 1'b1;
		issued++;
		do @(negedge clock); while (!pc_ready);
		rdata = pc_rdata;
		done_q.push_back({1'b1, rw, addr, wdata, rdata});
		done_order.push_back(1'b1);
		@(negedge clock);
		pc_request = 1'b0;
	endtask

	// Every completion goes through the model in completion order
	initial begin : compare_proc
		done_t d;
		bus_pkg::bus_data_t exp;
		forever begin
			@(posedge clock);
			while (done_q.size() != 0) begin
				d   = done_q.pop_front();
				exp = ref_access(d.addr, d.rw, d.wdata);
				if (!d.rw) check_data(d.port ? "o_pc_rdata" : "o_pb_rdata", d.rdata, exp);
				checked++;
			end
		end
	end

	always @(posedge clock) begin
		if (pb_ready && !pb_request) abort_run("port B saw ready with its request low");
		if (pc_ready && !pc_request) abort_run("port C saw ready with its request low");
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before all transactions completed");
	end

	initial begin : main_proc
		logic [31:0] r;
		int first;
		seed = 32'h164a1cd9;
		arst_n = 1'b0;
		{pb_rw, pb_request, pb_address, pb_wdata} = '0;
		{pc_rw, pc_request, pc_address, pc_wdata} = '0;
		issued = 0;
		checked = 0;
		sem_model = '0;
		for (int i = 0; i < 4; i++) scratch_model[i] = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		// Port B fills RAM words and reads them back
		for (int i = 0; i < RAM_SPAN; i++)
			b_transfer(1'b1, ram_slot_addr(i), $random(seed), rdata_b);
		for (int i = 0; i < RAM_SPAN; i++)
			b_transfer(1'b0, ram_slot_addr(i), '0, rdata_b);

		// Port C on the scratch words and an unmapped address
		for (int i = 0; i < 4; i++)
			c_transfer(1'b1, `REG_BASE + 32'(i * 4), $random(seed), rdata_c);
		for (int i = 0; i < 4; i++) c_transfer(1'b0, `REG_BASE + 32'(i * 4), '0, rdata_c);
		c_transfer(1'b1, 32'h0002_0040, 32'h1234_5678, rdata_c);
		c_transfer(1'b0, 32'h0002_0040, '0, rdata_c);

		// Both ports start on the same falling edge and B must finish first
		first = done_order.size();
		fork
			b_transfer(1'b0, ram_slot_addr(3), '0, rdata_b);
			c_transfer(1'b0, `REG_BASE + 32'd4, '0, rdata_c);
		join
		check_order("first completion", done_order[first], 1'b0);
		check_order("second completion", done_order[first + 1], 1'b1);

		// Semaphore 5 passed between the masters
		c_transfer(1'b0, SEM5_ADDR, '0, rdata_c);
		check_data("o_pc_rdata semaphore 5", rdata_c, 32'h0);
		b_transfer(1'b0, SEM5_ADDR, '0, rdata_b);
		check_data("o_pb_rdata semaphore 5", rdata_b, 32'h1);
		b_transfer(1'b1, SEM5_ADDR, 32'hFFFF_FFFF, rdata_b);
		c_transfer(1'b0, SEM5_ADDR, '0, rdata_c);
		check_data("o_pc_rdata semaphore 5", rdata_c, 32'h0);

		for (int i = 0; i < 2 * MIX_PER_PORT; i++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0, 2'd1: mix_addr[i] = ram_slot_addr(int'(r[6:2]));   // Only written RAM words
				2'd2:       mix_addr[i] = `REG_BASE + {27'd0, r[4:2], 2'b00};
				default:    mix_addr[i] = 32'h0002_0000 + {22'd0, r[9:2], 2'b00};
			endcase
			mix_rw[i]    = r[10];
			mix_wdata[i] = $random(seed);
		end
		fork
			for (int i = 0; i < MIX_PER_PORT; i++)
				b_transfer(mix_rw[i], mix_addr[i], mix_wdata[i], rdata_b);
			for (int i = MIX_PER_PORT; i < 2 * MIX_PER_PORT; i++)
				c_transfer(mix_rw[i], mix_addr[i], mix_wdata[i], rdata_c);
		join

		repeat (3) @(posedge clock);   // Let the compare process drain
		if (checked == NUM_TRANS && issued == NUM_TRANS) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run($sformatf("only %0d of %0d transactions were checked", checked, NUM_TRANS));
		end
	end

endmodule

// File: project.f
+incdir+hw
hw/bus_pkg.sv
hw/ctrl_pkg.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/wait_state_ram.sv
hw/semaphore_regs.sv
hw/dual_master_bus.sv
testbench/tb_dual_master_bus.sv

// File: Bender.yml
package:
  name: dual_master_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/bus_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/bus_arbiter.sv
      - hw/bus_decoder.sv
      - hw/wait_state_ram.sv
      - hw/semaphore_regs.sv
      - hw/dual_master_bus.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_dual_master_bus.sv
